/* design/traceback_pkg.sv */
`default_nettype none

package traceback_pkg;

	localparam int SEQ_MAX_LEN = 8;      // longest query or target
	localparam int CHUNK_LEN = 4;        // elements per sequence beat
	localparam int SEQ_BEATS = SEQ_MAX_LEN / CHUNK_LEN;
	localparam int BLOCK_LEN = 4;        // side of one direction block
	localparam int POS_WIDTH = 3;
	localparam int SLOT_WIDTH = $clog2(BLOCK_LEN);
	localparam int BEAT_CNT_WIDTH = $clog2(2 * SEQ_BEATS + 1);

	typedef logic [POS_WIDTH-1:0] pos_t;          // row or column index
	typedef logic signed [POS_WIDTH:0] col_t;     // column start, may go below 0
	typedef logic [SLOT_WIDTH-1:0] slot_t;        // row or column inside a block
	typedef logic [2:0] elem_t;

	localparam elem_t GAP = 3'd4;

	// direction cell layout is {h_src[1:0], i_ext, d_ext}
	typedef logic [3:0] dir_t;
	localparam int DIR_I_EXT = 1;
	localparam int DIR_D_EXT = 0;
	localparam logic [1:0] H_STOP = 2'd0;
	localparam logic [1:0] H_DIAG = 2'd1;
	localparam logic [1:0] H_FROM_I = 2'd2;
	localparam logic [1:0] H_FROM_D = 2'd3;

	typedef logic [CHUNK_LEN*$bits(elem_t)-1:0] chunk_t;  // element 0 in the low bits
	typedef logic [BLOCK_LEN*$bits(dir_t)-1:0] row_t;     // cell 0 in the low bits

	typedef enum logic [2:0] {M, I, I_OPEN, D, D_OPEN, STOP} trace_e;

endpackage

`default_nettype wire

/* design/sequence_store.sv */
`timescale 1ns/100ps
`default_nettype none

module sequence_store (
	input  logic                  clk,
	input  logic                  tb_valid,
	input  logic                  seq_valid,
	input  traceback_pkg::chunk_t seq_in,
	input  traceback_pkg::pos_t   max_position_x,
	input  traceback_pkg::pos_t   max_position_y,
	input  traceback_pkg::pos_t   query_idx,
	input  traceback_pkg::pos_t   target_idx,
	output logic                  seq_ready,
	output logic                  loaded,
	output traceback_pkg::pos_t   start_x,
	output traceback_pkg::pos_t   start_y,
	output traceback_pkg::elem_t  query_elem,
	output traceback_pkg::elem_t  target_elem
);

	traceback_pkg::elem_t query_mem [traceback_pkg::SEQ_MAX_LEN];
	traceback_pkg::elem_t target_mem [traceback_pkg::SEQ_MAX_LEN];
	logic [traceback_pkg::BEAT_CNT_WIDTH-1:0] beat_cnt;  // query beats first, then target
	logic beat_take;
	logic to_target;
	traceback_pkg::pos_t beat_base;

	assign beat_take = seq_valid & seq_ready;
	assign to_target = beat_cnt >= traceback_pkg::SEQ_BEATS;
	assign beat_base = traceback_pkg::pos_t'((beat_cnt % traceback_pkg::SEQ_BEATS)
		* traceback_pkg::CHUNK_LEN);

	always_ff @(posedge clk or posedge tb_valid) begin
		if (tb_valid) begin
			beat_cnt <= '0;
			seq_ready <= 1'b0;
			loaded <= 1'b0;
		end else begin
			if (beat_take)
				beat_cnt <= beat_cnt + 1'b1;
			// stays low after the last target beat until the next reset
			seq_ready <= beat_take ? (beat_cnt < 2 * traceback_pkg::SEQ_BEATS - 1)
				: (beat_cnt < 2 * traceback_pkg::SEQ_BEATS);
			if (beat_take && beat_cnt == 2 * traceback_pkg::SEQ_BEATS - 1)
				loaded <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_take) begin
			for (int k = 0; k < traceback_pkg::CHUNK_LEN; k++) begin
				if (to_target)
					target_mem[beat_base + k] <= seq_in[k*$bits(traceback_pkg::elem_t) +: 3];
				else
					query_mem[beat_base + k] <= seq_in[k*$bits(traceback_pkg::elem_t) +: 3];
			end
			if (beat_cnt == '0) begin  // start cell rides with the first beat
				start_x <= max_position_x;
				start_y <= max_position_y;
			end
		end
	end

	assign query_elem = query_mem[query_idx];
	assign target_elem = target_mem[target_idx];

endmodule

`default_nettype wire

/* design/block_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module block_fetch (
	input  logic                 clk,
	input  logic                 tb_valid,
	input  logic                 fetch_start,
	input  traceback_pkg::pos_t  corner_x,
	input  traceback_pkg::pos_t  corner_y,
	input  traceback_pkg::pos_t  pos_x,
	input  traceback_pkg::pos_t  pos_y,
	input  logic                 row_req_ready,
	input  logic                 row_valid,
	input  traceback_pkg::row_t  row_data,
	output logic                 row_req_valid,
	output traceback_pkg::pos_t  row_num,
	output traceback_pkg::col_t  col_start,
	output logic                 block_ready,
	output logic                 cell_hit,
	output traceback_pkg::dir_t  cell_dir
);

	traceback_pkg::row_t blk [traceback_pkg::BLOCK_LEN];  // slot 0 holds row corner_x
	traceback_pkg::pos_t corner_x_q;
	traceback_pkg::pos_t corner_y_q;
	traceback_pkg::pos_t dx;
	traceback_pkg::pos_t dy;
	traceback_pkg::slot_t req_cnt;   // rows requested so far
	traceback_pkg::slot_t rsp_cnt;   // rows returned so far
	traceback_pkg::slot_t row_sel;
	traceback_pkg::slot_t col_sel;
	logic req_take;

	assign req_take = row_req_valid & row_req_ready;
	assign row_num = corner_x_q - traceback_pkg::pos_t'(req_cnt);  // descending rows
	assign col_start = traceback_pkg::col_t'({1'b0, corner_y_q})
		- traceback_pkg::col_t'(traceback_pkg::BLOCK_LEN - 1);

	always_ff @(posedge clk or posedge tb_valid) begin
		if (tb_valid) begin
			row_req_valid <= 1'b0;
			req_cnt <= '0;
			rsp_cnt <= '0;
			block_ready <= 1'b0;
			corner_x_q <= '0;
			corner_y_q <= '0;
		end else begin
			block_ready <= row_valid
				&& rsp_cnt == traceback_pkg::slot_t'(traceback_pkg::BLOCK_LEN - 1);
			if (fetch_start) begin
				corner_x_q <= corner_x;
				corner_y_q <= corner_y;
				row_req_valid <= 1'b1;
				req_cnt <= '0;
				rsp_cnt <= '0;
			end else begin
				// each side keeps its own count as requests and responses overlap
				if (req_take) begin
					req_cnt <= req_cnt + 1'b1;
					if (req_cnt == traceback_pkg::slot_t'(traceback_pkg::BLOCK_LEN - 1))
						row_req_valid <= 1'b0;
				end
				if (row_valid)
					rsp_cnt <= rsp_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid)
			blk[rsp_cnt] <= row_data;
	end

	// distance back from the corner picks the slot
	assign dx = corner_x_q - pos_x;
	assign dy = corner_y_q - pos_y;
	assign cell_hit = pos_x <= corner_x_q && pos_y <= corner_y_q
		&& dx < traceback_pkg::BLOCK_LEN && dy < traceback_pkg::BLOCK_LEN;
	assign row_sel = dx[traceback_pkg::SLOT_WIDTH-1:0];
	assign col_sel = traceback_pkg::slot_t'(traceback_pkg::BLOCK_LEN - 1)
		- dy[traceback_pkg::SLOT_WIDTH-1:0];  // row data starts at corner_y - 3
	assign cell_dir = blk[row_sel][col_sel*$bits(traceback_pkg::dir_t) +: 4];

endmodule

`default_nettype wire

/* design/trace_walker.sv */
`timescale 1ns/100ps
`default_nettype none

module trace_walker (
	input  logic                  clk,
	input  logic                  tb_valid,
	input  logic                  loaded,
	input  traceback_pkg::pos_t   start_x,
	input  traceback_pkg::pos_t   start_y,
	input  traceback_pkg::elem_t  query_elem,
	input  traceback_pkg::elem_t  target_elem,
	input  logic                  block_ready,
	input  logic                  cell_hit,
	input  traceback_pkg::dir_t   cell_dir,
	input  logic                  out_ready,
	output traceback_pkg::pos_t   query_idx,
	output traceback_pkg::pos_t   target_idx,
	output logic                  fetch_start,
	output traceback_pkg::pos_t   corner_x,
	output traceback_pkg::pos_t   corner_y,
	output traceback_pkg::pos_t   pos_x,
	output traceback_pkg::pos_t   pos_y,
	output logic                  out_valid,
	output traceback_pkg::elem_t  query_out,
	output traceback_pkg::elem_t  target_out,
	output logic                  done
);

	typedef enum logic [1:0] {wait_load, fetch, walk, finish} state_e;

	state_e state;
	traceback_pkg::trace_e prev_sym;
	traceback_pkg::trace_e next_sym;
	logic step_en;
	logic at_edge;  // coordinate about to step is already 0

	assign query_idx = pos_x;
	assign target_idx = pos_y;
	assign step_en = state == walk && cell_hit && (!out_valid || out_ready);

	always_comb begin
		next_sym = traceback_pkg::STOP;
		case (prev_sym)
			traceback_pkg::I: next_sym = cell_dir[traceback_pkg::DIR_I_EXT]
				? traceback_pkg::I : traceback_pkg::I_OPEN;
			traceback_pkg::D: next_sym = cell_dir[traceback_pkg::DIR_D_EXT]
				? traceback_pkg::D : traceback_pkg::D_OPEN;
			default: begin  // in H
				case (cell_dir[3:2])
					traceback_pkg::H_STOP: next_sym = traceback_pkg::STOP;
					traceback_pkg::H_DIAG: next_sym = traceback_pkg::M;
					traceback_pkg::H_FROM_I: next_sym = traceback_pkg::I;
					traceback_pkg::H_FROM_D: next_sym = traceback_pkg::D;
				endcase
			end
		endcase
	end

	always_comb begin
		case (next_sym)
			traceback_pkg::M: at_edge = pos_x == '0 || pos_y == '0;
			traceback_pkg::I, traceback_pkg::I_OPEN: at_edge = pos_y == '0;
			traceback_pkg::D, traceback_pkg::D_OPEN: at_edge = pos_x == '0;
			default: at_edge = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge tb_valid) begin
		if (tb_valid) begin
			state <= wait_load;
			prev_sym <= traceback_pkg::M;
			fetch_start <= 1'b0;
			corner_x <= '0;
			corner_y <= '0;
			pos_x <= '0;
			pos_y <= '0;
			out_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			if (out_valid && out_ready)
				out_valid <= 1'b0;
			case (state)
				wait_load: begin
					if (loaded) begin
						pos_x <= start_x;
						pos_y <= start_y;
						corner_x <= start_x;
						corner_y <= start_y;
						prev_sym <= traceback_pkg::M;
						fetch_start <= 1'b1;
						state <= fetch;
					end
				end
				fetch: begin
					if (block_ready)
						state <= walk;
				end
				walk: begin
					if (!cell_hit) begin
						// current cell becomes the corner of the next block
						corner_x <= pos_x;
						corner_y <= pos_y;
						fetch_start <= 1'b1;
						state <= fetch;
					end else if (step_en) begin
						prev_sym <= next_sym;
						case (next_sym)
							traceback_pkg::M: begin
								pos_x <= pos_x - 1'b1;
								pos_y <= pos_y - 1'b1;
							end
							traceback_pkg::I, traceback_pkg::I_OPEN: pos_y <= pos_y - 1'b1;
							traceback_pkg::D, traceback_pkg::D_OPEN: pos_x <= pos_x - 1'b1;
							default: done <= 1'b1;  // stop emits nothing
						endcase
						if (next_sym == traceback_pkg::STOP)
							state <= finish;
						else begin
							out_valid <= 1'b1;
							if (at_edge)
								state <= finish;
						end
					end
				end
				finish: begin
					if (!out_valid || out_ready)
						done <= 1'b1;  // last pair has left
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (step_en) begin
			query_out <= next_sym inside {traceback_pkg::M, traceback_pkg::D, traceback_pkg::D_OPEN}
				? query_elem : traceback_pkg::GAP;
			target_out <= next_sym inside {traceback_pkg::M, traceback_pkg::I, traceback_pkg::I_OPEN}
				? target_elem : traceback_pkg::GAP;
		end
	end

endmodule

`default_nettype wire

/* design/traceback_top.sv */
`timescale 1ns/100ps
`default_nettype none

module traceback_top (
	input  logic                  clk,
	input  logic                  tb_valid,
	input  logic                  seq_valid,
	input  traceback_pkg::chunk_t seq_in,
	input  traceback_pkg::pos_t   max_position_x,
	input  traceback_pkg::pos_t   max_position_y,
	input  logic                  row_req_ready,
	input  logic                  row_valid,
	input  traceback_pkg::row_t   row_data,
	input  logic                  out_ready,
	output logic                  seq_ready,
	output logic                  row_req_valid,
	output traceback_pkg::pos_t   row_num,
	output traceback_pkg::col_t   col_start,
	output logic                  out_valid,
	output traceback_pkg::elem_t  query_out,
	output traceback_pkg::elem_t  target_out,
	output logic                  done
);

	logic loaded;
	logic fetch_start;
	logic block_ready;
	logic cell_hit;
	traceback_pkg::pos_t start_x;
	traceback_pkg::pos_t start_y;
	traceback_pkg::pos_t query_idx;
	traceback_pkg::pos_t target_idx;
	traceback_pkg::pos_t corner_x;
	traceback_pkg::pos_t corner_y;
	traceback_pkg::pos_t pos_x;
	traceback_pkg::pos_t pos_y;
	traceback_pkg::elem_t query_elem;
	traceback_pkg::elem_t target_elem;
	traceback_pkg::dir_t cell_dir;

	sequence_store u_seq (
		.clk(clk), .tb_valid(tb_valid), .seq_valid(seq_valid), .seq_in(seq_in),
		.max_position_x(max_position_x), .max_position_y(max_position_y),
		.query_idx(query_idx), .target_idx(target_idx), .seq_ready(seq_ready),
		.loaded(loaded), .start_x(start_x), .start_y(start_y),
		.query_elem(query_elem), .target_elem(target_elem)
	);

	block_fetch u_fetch (
		.clk(clk), .tb_valid(tb_valid), .fetch_start(fetch_start),
		.corner_x(corner_x), .corner_y(corner_y), .pos_x(pos_x), .pos_y(pos_y),
		.row_req_ready(row_req_ready), .row_valid(row_valid), .row_data(row_data),
		.row_req_valid(row_req_valid), .row_num(row_num), .col_start(col_start),
		.block_ready(block_ready), .cell_hit(cell_hit), .cell_dir(cell_dir)
	);

	trace_walker u_walk (
		.clk(clk), .tb_valid(tb_valid), .loaded(loaded), .start_x(start_x),
		.start_y(start_y), .query_elem(query_elem), .target_elem(target_elem),
		.block_ready(block_ready), .cell_hit(cell_hit), .cell_dir(cell_dir),
		.out_ready(out_ready), .query_idx(query_idx), .target_idx(target_idx),
		.fetch_start(fetch_start), .corner_x(corner_x), .corner_y(corner_y),
		.pos_x(pos_x), .pos_y(pos_y), .out_valid(out_valid), .query_out(query_out),
		.target_out(target_out), .done(done)
	);

endmodule

`default_nettype wire

/* bench/traceback_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module traceback_tb;

	localparam int MAX_CASES = 8;
	localparam int REC_LEN = 27;          // words per case record
	localparam int CYCLES_PER_CASE = 400;

	logic clk = 1'b0;
	logic tb_valid;
	logic seq_valid;
	traceback_pkg::chunk_t seq_in;
	traceback_pkg::pos_t max_position_x;
	traceback_pkg::pos_t max_position_y;
	logic row_req_ready;
	logic row_valid;
	traceback_pkg::row_t row_data;
	logic out_ready;
	logic seq_ready;
	logic row_req_valid;
	logic out_valid;
	logic done;
	traceback_pkg::pos_t row_num;
	traceback_pkg::col_t col_start;
	traceback_pkg::elem_t query_out;
	traceback_pkg::elem_t target_out;

	logic [31:0] cases [1 + MAX_CASES*REC_LEN];
	int num_cases;
	int base;            // first word of the running case
	int pair_idx;
	int req_idx;
	int cycle_cnt;
	int last_due;
	logic active;
	traceback_pkg::row_t rsp_q [$];  // rows in flight
	int rsp_due [$];

	traceback_top DUT (
		.clk(clk), .tb_valid(tb_valid), .seq_valid(seq_valid), .seq_in(seq_in),
		.max_position_x(max_position_x), .max_position_y(max_position_y),
		.row_req_ready(row_req_ready), .row_valid(row_valid), .row_data(row_data),
		.out_ready(out_ready), .seq_ready(seq_ready), .row_req_valid(row_req_valid),
		.row_num(row_num), .col_start(col_start), .out_valid(out_valid),
		.query_out(query_out), .target_out(target_out), .done(done)
	);

	always #5 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_pair(input traceback_pkg::elem_t exp_q, exp_t, got_q, got_t);
		if (got_q !== exp_q || got_t !== exp_t)
			stop_on_error($sformatf("mismatch at %0t: query_out/target_out expected %0d/%0d got %0d/%0d",
				$time, exp_q, exp_t, got_q, got_t));
	endtask

	task automatic check_row_req(input traceback_pkg::pos_t exp_row, got_row,
		input traceback_pkg::col_t exp_col, got_col);
		if (got_row !== exp_row)
			stop_on_error($sformatf("mismatch at %0t: row_num expected %0d got %0d",
				$time, exp_row, got_row));
		if (got_col !== exp_col)
			stop_on_error($sformatf("mismatch at %0t: col_start expected %0d got %0d",
				$time, exp_col, got_col));
	endtask

	task automatic check_done(input string name, input logic exp_val, got_val);
		if (got_val !== exp_val)
			stop_on_error($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, exp_val, got_val));
	endtask

	// cells left of column 0 read as stop
	function automatic traceback_pkg::row_t mem_row(input traceback_pkg::pos_t r,
		input traceback_pkg::col_t cs);
		traceback_pkg::row_t row;
		int col;
		row = '0;
		for (int j = 0; j < traceback_pkg::BLOCK_LEN; j++) begin
			col = int'(cs) + j;
			if (col >= 0 && col < traceback_pkg::SEQ_MAX_LEN)
				row[j*4 +: 4] = cases[base + 6 + r][col*4 +: 4];
		end
		return row;
	endfunction

	// memory model, output checks and run limit
	always @(posedge clk) begin : model
		logic [31:0] word;
		int due;
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLES_PER_CASE * num_cases)
			stop_on_error("timeout: the walks did not finish within the cycle limit");
		if (tb_valid || !active) begin
			row_valid <= 1'b0;
			rsp_q.delete();
			rsp_due.delete();
		end else begin
			row_req_ready <= ($urandom % 3) != 0;
			out_ready <= ($urandom % 4) != 0;
			row_valid <= 1'b0;
			if (rsp_q.size() > 0 && rsp_due[0] <= cycle_cnt) begin
				row_valid <= 1'b1;
				row_data <= rsp_q.pop_front();
				void'(rsp_due.pop_front());
			end
			if (row_req_valid && row_req_ready) begin
				if (req_idx / 4 >= cases[base + 23])
					stop_on_error("row request issued for a block that was not expected");
				word = cases[base + 24 + req_idx / 4];  // corner as {x, y}
				check_row_req(traceback_pkg::pos_t'(word[6:4] - req_idx % 4), row_num,
					traceback_pkg::col_t'({1'b0, word[2:0]}) - traceback_pkg::col_t'(3), col_start);
				due = cycle_cnt + 1 + $urandom % 3;
				if (due <= last_due)
					due = last_due + 1;  // keep responses in order
				last_due = due;
				rsp_q.push_back(mem_row(row_num, col_start));
				rsp_due.push_back(due);
				req_idx = req_idx + 1;
			end
			if (out_valid && out_ready) begin
				if (pair_idx >= cases[base + 14])
					stop_on_error("DUT emitted more pairs than expected");
				word = cases[base + 15 + pair_idx];
				check_pair(traceback_pkg::elem_t'(word[7:4]), traceback_pkg::elem_t'(word[3:0]),
					query_out, target_out);
				pair_idx = pair_idx + 1;
			end
		end
	end

	task automatic run_case(input int c);
		int abort_at;
		@(posedge clk);
		tb_valid <= 1'b1;
		active <= 1'b0;
		repeat (5) @(posedge clk);
		base = 1 + c * REC_LEN;
		pair_idx = 0;
		req_idx = 0;
		last_due = 0;
		abort_at = cases[base + 26];
		tb_valid <= 1'b0;
		active <= 1'b1;
		check_done("out_valid", 1'b0, out_valid);
		check_done("done", 1'b0, done);
		check_done("row_req_valid", 1'b0, row_req_valid);
		max_position_x <= traceback_pkg::pos_t'(cases[base + 4]);
		max_position_y <= traceback_pkg::pos_t'(cases[base + 5]);
		for (int b = 0; b < 2 * traceback_pkg::SEQ_BEATS; b++) begin
			seq_valid <= 1'b1;
			seq_in <= traceback_pkg::chunk_t'(cases[base + b]);
			do @(posedge clk); while (!seq_ready);
		end
		seq_valid <= 1'b0;
		while (!done && !(abort_at != 0 && pair_idx >= abort_at))
			@(negedge clk);
		if (abort_at == 0) begin  // aborted case is cut short by the next reset
			if (pair_idx != cases[base + 14])
				stop_on_error($sformatf("case %0d ended after %0d pairs, expected %0d",
					c, pair_idx, cases[base + 14]));
			if (req_idx != 4 * cases[base + 23])
				stop_on_error($sformatf("case %0d issued %0d row requests, expected %0d",
					c, req_idx, 4 * cases[base + 23]));
			check_done("out_valid", 1'b0, out_valid);
			check_done("seq_ready", 1'b0, seq_ready);
			check_done("row_req_valid", 1'b0, row_req_valid);
		end
	endtask

	initial begin
		void'($urandom(32));
		tb_valid = 1'b1;
		seq_valid = 1'b0;
		seq_in = '0;
		max_position_x = '0;
		max_position_y = '0;
		row_req_ready = 1'b0;
		row_valid = 1'b0;
		row_data = '0;
		out_ready = 1'b0;
		active = 1'b0;
		cycle_cnt = 0;
		base = 1;
		$readmemh("bench/traceback_cases.txt", cases);
		num_cases = cases[0];
		if (num_cases < 1 || num_cases > MAX_CASES)
			stop_on_error("case file does not hold a usable case count");
		for (int c = 0; c < num_cases; c++)
			run_case(c);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/traceback_cases.txt */
// case count, then per case: query beats, target beats, start x, start y / rows 0..7
// / pair count, 8 pairs {q,t}, corner count, 2 corners {x,y}, abort after n pairs
7
0D1 053 688 252 3 3
44444444 44444444 44444444 44444444 00000000 00000000 00000000 00000000
4 03 32 21 10 00 00 00 00 1 33 00 0
0D1 053 688 252 3 3
00000004 00000002 00000001 0000821C 00000000 00000000 00000000 00000000
7 43 42 41 04 34 24 10 00 1 33 00 0
0D1 053 688 252 7 7
44444444 44444444 44444444 44444444 44444444 44444444 44444444 44444444
8 01 11 22 32 03 32 21 10 2 77 33 0
0D1 053 688 252 5 2
00000004 00000040 00000020 00000010 000000C0 00000400 00000000 00000000
6 22 34 04 34 21 10 00 00 2 52 11 0
0D1 053 688 252 3 3
00000004 00000000 00000400 00004000 00000000 00000000 00000000 00000000
2 03 32 00 00 00 00 00 00 1 33 00 0
0D1 053 688 252 7 7
44444444 44444444 44444444 44444444 44444444 44444444 44444444 44444444
8 01 11 22 32 03 32 21 10 2 77 33 2
0D1 053 688 252 3 3
44444444 44444444 44444444 44444444 00000000 00000000 00000000 00000000
4 03 32 21 10 00 00 00 00 1 33 00 0

/* list.f */
design/traceback_pkg.sv
design/sequence_store.sv
design/block_fetch.sv
design/trace_walker.sv
design/traceback_top.sv
bench/traceback_tb.sv

/* Bender.yml */
package:
  name: traceback

sources:
  - files:
      - design/traceback_pkg.sv
      - design/sequence_store.sv
      - design/block_fetch.sv
      - design/trace_walker.sv
      - design/traceback_top.sv
  - target: test
    files:
      - bench/traceback_tb.sv
